//--- memtest_ctrl.f
+incdir+.
memtest_pkg.sv
pll_step_table.sv
key_cmd_decoder.sv
pll_reconfig_seq.sv
elapsed_timer.sv
memtest_ctrl_top.sv
tb_clk_gen.sv
memtest_properties.sv
memtest_ctrl_tb.sv

//--- memtest_ctrl_tb.sv
`timescale 1ns/1ps
`include "memtest_config.svh"
`default_nettype none

module memtest_ctrl_tb
    import memtest_pkg::*;
();

    localparam int TICKS_PER_SEC = 20;
    localparam int STALL_FACTOR  = 4;   // Worst slowdown from waitrequest
    localparam int SEQ_CYCLES    = 15 * 8 * STALL_FACTOR;
    localparam int N_RECFG       = 32;  // Reconfigurations over all tests
    localparam int TIMER_CYCLES  = 60 * TICKS_PER_SEC * 2 + TICKS_PER_SEC;
    localparam int SETUP_CYCLES  = 400;  // Resets and key gaps

    logic         CLK_50M;
    logic         rst;
    key_event_t   key_evt;
    logic         mgmt_waitrequest;
    logic         pll_locked;
    logic         mem_fail;
    mgmt_cmd_t    mgmt;
    logic         pll_reset;
    logic         busy;
    ctrl_status_t status;
    elapsed_t     elapsed;

    mgmt_cmd_t got_q[$];
    mgmt_cmd_t exp_q[$];
    int        reset_at_q[$];   // Writes seen when pll_reset rose
    int        exp_reset_q[$];
    logic      reset_seen;
    int        lock_wait;       // Cycles until the PLL relocks
    int        err_cnt;
    int        check_cnt;
    int        tests_run;

    tb_clk_gen #(.PERIOD_NS(20)) clk_gen_i (.CLK_50M(CLK_50M));

    memtest_ctrl_top #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) memtest_ctrl_top_i (
        .CLK_50M          (CLK_50M),
        .rst              (rst),
        .key_evt          (key_evt),
        .mgmt_waitrequest (mgmt_waitrequest),
        .pll_locked       (pll_locked),
        .mem_fail         (mem_fail),
        .mgmt             (mgmt),
        .pll_reset        (pll_reset),
        .busy             (busy),
        .status           (status),
        .elapsed          (elapsed)
    );

    bind memtest_ctrl_top memtest_properties memtest_properties_i (
        .CLK_50M   (CLK_50M),
        .rst       (rst),
        .mgmt      (mgmt),
        .pll_reset (pll_reset),
        .busy      (busy),
        .status    (status),
        .elapsed   (elapsed)
    );

    // Bus monitor, samples mid-cycle
    always @(negedge CLK_50M) begin
        if (rst) begin
            reset_seen = 1'b0;
        end else begin
            if (mgmt.write)
                got_q.push_back(mgmt);
            if (pll_reset && !reset_seen)
                reset_at_q.push_back(got_q.size());
            reset_seen = pll_reset;
        end
    end

    // PLL lock is lost in reset and comes back a few cycles later
    always @(negedge CLK_50M) begin
        if (pll_reset) begin
            lock_wait  = 6;
            pll_locked = 1'b0;
        end else if (lock_wait > 0) begin
            lock_wait--;
        end else begin
            pll_locked = 1'b1;
        end
    end

    function automatic pll_cfg_t cfg_for_step(input int p);
        pll_cfg_t c;
        case (p)
            0: c = '{`MT_M_0, `MT_K_0, `MT_C_0, `MT_PH_0, `MT_FREQ_0};
            1: c = '{`MT_M_1, `MT_K_1, `MT_C_1, `MT_PH_1, `MT_FREQ_1};
            2: c = '{`MT_M_2, `MT_K_2, `MT_C_2, `MT_PH_2, `MT_FREQ_2};
            3: c = '{`MT_M_3, `MT_K_3, `MT_C_3, `MT_PH_3, `MT_FREQ_3};
            4: c = '{`MT_M_4, `MT_K_4, `MT_C_4, `MT_PH_4, `MT_FREQ_4};
            5: c = '{`MT_M_5, `MT_K_5, `MT_C_5, `MT_PH_5, `MT_FREQ_5};
            6: c = '{`MT_M_6, `MT_K_6, `MT_C_6, `MT_PH_6, `MT_FREQ_6};
            7: c = '{`MT_M_7, `MT_K_7, `MT_C_7, `MT_PH_7, `MT_FREQ_7};
            8: c = '{`MT_M_8, `MT_K_8, `MT_C_8, `MT_PH_8, `MT_FREQ_8};
            9: c = '{`MT_M_9, `MT_K_9, `MT_C_9, `MT_PH_9, `MT_FREQ_9};
            default: c = '{`MT_M_10, `MT_K_10, `MT_C_10, `MT_PH_10, `MT_FREQ_10};
        endcase
        return c;
    endfunction

    function automatic ctrl_status_t status_for(input int p, input logic a, input logic s);
        pll_cfg_t c;
        c = cfg_for_step(p);
        return '{pos: 4'(p), auto: a, ph_shift: s, freq_code: c.freq_code};
    endfunction

    // One full reconfiguration to step p with target phase t
    task automatic add_expected(input int p, input logic [31:0] t);
        pll_cfg_t    c;
        logic [31:0] base;
        logic [31:0] ph;
        c    = cfg_for_step(p);
        base = `MT_PH_0;
        exp_q.push_back('{1'b1, 6'd0, 32'd0});
        exp_q.push_back('{1'b1, 6'd4, c.m});
        exp_q.push_back('{1'b1, 6'd7, c.k});
        exp_q.push_back('{1'b1, 6'd3, 32'h0001_0000});
        exp_q.push_back('{1'b1, 6'd5, c.c});
        exp_q.push_back('{1'b1, 6'd5, c.c | 32'h0004_0000});
        exp_q.push_back('{1'b1, 6'd9, 32'd1});
        exp_q.push_back('{1'b1, 6'd8, 32'd7});
        exp_q.push_back('{1'b1, 6'd2, 32'd0});
        exp_reset_q.push_back(exp_q.size());
        if (t != base) begin
            ph = ((t < base) ? base - t : t - base) | 32'h0001_0000;
            if (t < base)
                ph = ph | 32'h0020_0000;  // Direction bit
            exp_q.push_back('{1'b1, 6'd0, 32'd0});
            exp_q.push_back('{1'b1, 6'd6, ph});
            exp_q.push_back('{1'b1, 6'd2, 32'd0});
        end
    endtask

    task automatic clear_log();
        got_q.delete();
        exp_q.delete();
        reset_at_q.delete();
        exp_reset_q.delete();
    endtask

    task automatic check_mgmt(input string name, input mgmt_cmd_t got, input mgmt_cmd_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("ERR %s exp addr=%h data=%h got write=%h addr=%h data=%h",
                     name, exp.address, exp.writedata, got.write, got.address, got.writedata);
            err_cnt++;
        end
    endtask

    task automatic check_status(input string name, input ctrl_status_t got,
                                input ctrl_status_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("ERR %s exp pos=%h auto=%h ph_shift=%h freq=%h got %h %h %h %h",
                     name, exp.pos, exp.auto, exp.ph_shift, exp.freq_code,
                     got.pos, got.auto, got.ph_shift, got.freq_code);
            err_cnt++;
        end
    endtask

    task automatic check_elapsed(input string name, input elapsed_t got, input elapsed_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("ERR %s exp mins=%h secs=%h got mins=%h secs=%h",
                     name, exp.mins, exp.secs, got.mins, got.secs);
            err_cnt++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            $display("ERR %s exp %h got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    // Compares the logged writes and reset pulses, then empties the log
    task automatic check_writes(input string what);
        int n;
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        if (got_q.size() != exp_q.size()) begin
            $display("%s: expected %0d writes but saw %0d", what, exp_q.size(), got_q.size());
            err_cnt++;
        end
        for (int i = 0; i < n; i++)
            check_mgmt($sformatf("mgmt[%0d]", i), got_q[i], exp_q[i]);
        if (reset_at_q.size() != exp_reset_q.size()) begin
            $display("%s: expected %0d pll_reset pulses but saw %0d",
                     what, exp_reset_q.size(), reset_at_q.size());
            err_cnt++;
        end else begin
            foreach (reset_at_q[i]) begin
                if (reset_at_q[i] != exp_reset_q[i]) begin
                    $display("%s: pll_reset pulse came after %0d writes instead of %0d",
                             what, reset_at_q[i], exp_reset_q[i]);
                    err_cnt++;
                end
            end
        end
        check_level("pll_reset", pll_reset, 1'b0);  // Pulse must have ended
        clear_log();
    endtask

    task automatic drive_stalls();
        forever begin
            @(negedge CLK_50M);
            mgmt_waitrequest = ($urandom % 4) == 0;  // About one stall in four
        end
    endtask

    task automatic apply_reset();
        @(negedge CLK_50M);
        rst     = 1'b1;
        key_evt = '0;  // Toggle back to the decoder's idle value
        repeat (8) @(negedge CLK_50M);
        rst = 1'b0;
        clear_log();
    endtask

    task automatic send_key(input logic [7:0] code, input logic pressed);
        @(negedge CLK_50M);
        key_evt.toggle  = ~key_evt.toggle;
        key_evt.pressed = pressed;
        key_evt.code    = code;
    endtask

    // Start shows up two cycles after the key
    task automatic wait_idle(input string what);
        int n;
        repeat (3) @(negedge CLK_50M);
        n = 0;
        while (busy && n < SEQ_CYCLES) begin
            @(negedge CLK_50M);
            n++;
        end
        if (busy) begin
            $display("%s: sequencer still busy after %0d cycles", what, n);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        tests_run++;
        if (err_cnt == errs_at_start)
            $display("ok      %s", name);
        else
            $display("FAILED  %s, %0d errors", name, err_cnt - errs_at_start);
    endtask

    task automatic reset_state();
        int errs;
        errs = err_cnt;
        check_level("mgmt.write", mgmt.write, 1'b0);
        check_level("pll_reset", pll_reset, 1'b0);
        check_level("busy", busy, 1'b0);
        check_status("status", status, status_for(0, 1'b0, 1'b0));
        check_elapsed("elapsed", elapsed, '0);
        report_test("reset state", errs);
    endtask

    task automatic down_with_stalls();
        int errs;
        errs = err_cnt;
        send_key(`MT_KEY_DOWN, 1'b1);
        wait_idle("down");
        check_status("status", status, status_for(1, 1'b0, 1'b0));
        add_expected(1, `MT_PH_1);
        check_writes("down");
        report_test("down key with stalls", errs);
    endtask

    task automatic step_limits();
        int       errs;
        pll_cfg_t c;
        errs = err_cnt;
        send_key(`MT_KEY_UP, 1'b1);
        wait_idle("up to step 0");
        add_expected(0, `MT_PH_0);
        check_writes("up to step 0");
        send_key(`MT_KEY_UP, 1'b1);  // Already at the top step
        wait_idle("up at step 0");
        check_writes("up at step 0");
        check_status("status", status, status_for(0, 1'b0, 1'b0));
        for (int i = 1; i <= 10; i++) begin
            send_key(`MT_KEY_DOWN, 1'b1);
            wait_idle("down");
            c = cfg_for_step(i);
            add_expected(i, c.phase);
            check_writes($sformatf("down to step %0d", i));
        end
        send_key(`MT_KEY_DOWN, 1'b1);
        wait_idle("down at step 10");
        check_writes("down at step 10");
        check_status("status", status, status_for(10, 1'b0, 1'b0));
        report_test("step limits", errs);
    endtask

    task automatic phase_adjust();
        int errs;
        errs = err_cnt;
        apply_reset();
        send_key(`MT_KEY_SHIFT, 1'b1);
        wait_idle("shift make");
        check_writes("shift make");
        for (int i = 1; i <= 2; i++) begin
            send_key(`MT_KEY_RIGHT, 1'b1);
            wait_idle("shift+right");
            add_expected(0, `MT_PH_0 + i);
            check_writes("shift+right");
        end
        check_status("status", status, status_for(0, 1'b0, 1'b1));
        for (int i = 1; i <= 3; i++) begin
            send_key(`MT_KEY_LEFT, 1'b1);
            wait_idle("shift+left");
            add_expected(0, `MT_PH_0 + 2 - i);  // Passes through the base phase
            check_writes("shift+left");
        end
        send_key(`MT_KEY_SHIFT, 1'b0);
        wait_idle("shift break");
        send_key(`MT_KEY_ENTER, 1'b1);
        wait_idle("enter");
        add_expected(0, `MT_PH_0);
        check_writes("enter at step 0");
        check_status("status", status, status_for(0, 1'b0, 1'b0));
        report_test("phase adjust", errs);
    endtask

    task automatic auto_stepping();
        int       errs;
        int       n;
        pll_cfg_t c;
        errs = err_cnt;
        send_key(`MT_KEY_AUTO, 1'b1);
        wait_idle("auto");
        add_expected(0, `MT_PH_0);
        check_writes("auto");
        check_status("status", status, status_for(0, 1'b1, 1'b0));
        @(negedge CLK_50M);
        mem_fail = 1'b1;
        n = 0;
        while (status.pos != 4'd10 && n < 10 * SEQ_CYCLES) begin
            @(negedge CLK_50M);
            n++;
        end
        if (status.pos != 4'd10) begin
            $display("auto mode stopped at step %0d", status.pos);
            err_cnt++;
        end
        wait_idle("auto stepping");
        mem_fail = 1'b0;
        for (int i = 1; i <= 10; i++) begin
            c = cfg_for_step(i);
            add_expected(i, c.phase);
        end
        check_writes("auto stepping");
        check_status("status", status, status_for(10, 1'b1, 1'b0));
        send_key(`MT_KEY_UP, 1'b1);
        wait_idle("up in auto");
        add_expected(9, `MT_PH_9);
        check_writes("up in auto");
        check_status("status", status, status_for(9, 1'b0, 1'b0));
        report_test("auto mode", errs);
    endtask

    task automatic timer_count();
        int errs;
        int n;
        errs = err_cnt;
        send_key(`MT_KEY_ENTER, 1'b1);
        wait_idle("enter before timer");
        add_expected(9, `MT_PH_9);
        check_writes("enter before timer");
        // Two minutes, then half a tick into the next second
        repeat (TIMER_CYCLES - TICKS_PER_SEC + TICKS_PER_SEC / 2) @(negedge CLK_50M);
        check_elapsed("elapsed", elapsed, '{mins: 16'h0002, secs: 16'd120});
        send_key(`MT_KEY_ENTER, 1'b1);
        n = 0;
        while (!busy && n < 8) begin
            @(negedge CLK_50M);
            n++;
        end
        if (!busy) begin
            $display("enter did not start a reconfiguration");
            err_cnt++;
        end
        @(negedge CLK_50M);
        check_elapsed("elapsed", elapsed, '0);
        wait_idle("timer clear");
        add_expected(9, `MT_PH_9);
        check_writes("timer clear");
        report_test("elapsed timer", errs);
    endtask

    initial begin
        void'($urandom(32'he8d5_7cde));
        rst              = 1'b1;
        key_evt          = '0;
        mgmt_waitrequest = 1'b0;
        pll_locked       = 1'b1;
        lock_wait        = 0;
        mem_fail         = 1'b0;
        err_cnt          = 0;
        check_cnt        = 0;
        tests_run        = 0;
        fork
            drive_stalls();
        join_none
        apply_reset();
        reset_state();
        down_with_stalls();
        step_limits();
        phase_adjust();
        auto_stepping();
        timer_count();
        $display("%0d tests run, %0d checks, %0d errors", tests_run, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // Every reconfiguration at worst-case stalls, plus the timer run
    initial begin
        #((N_RECFG * SEQ_CYCLES + TIMER_CYCLES + SETUP_CYCLES) * 20);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- memtest_properties.sv
`timescale 1ns/1ps
`include "memtest_config.svh"
`default_nettype none

module memtest_properties
    import memtest_pkg::*;
(
    input logic         CLK_50M,
    input logic         rst,
    input mgmt_cmd_t    mgmt,
    input logic         pll_reset,
    input logic         busy,
    input ctrl_status_t status,
    input elapsed_t     elapsed
);

    localparam logic [3:0] LAST_POS = 4'(`MT_NUM_STEPS - 1);

    // Writes are spaced by whole action slots
    write_spacing: assert property (@(posedge CLK_50M) disable iff (rst)
        mgmt.write |=> !mgmt.write)
        else $error("mgmt.write high on two consecutive cycles");

    reset_apart: assert property (@(posedge CLK_50M) disable iff (rst)
        !(pll_reset && mgmt.write))
        else $error("pll_reset and mgmt.write high together");

    pos_range: assert property (@(posedge CLK_50M) disable iff (rst)
        status.pos <= LAST_POS)
        else $error("status.pos above the last step");

    // Timer clears on the edge after busy is seen
    timer_held: assert property (@(posedge CLK_50M) disable iff (rst)
        busy |=> elapsed == '0)
        else $error("elapsed not held at zero while busy");

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic CLK_50M
);

    initial CLK_50M = 1'b0;

    always #(PERIOD_NS / 2.0) CLK_50M = ~CLK_50M;  // 50 MHz at the default period

endmodule

`default_nettype wire

//--- memtest_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module memtest_ctrl_top
    import memtest_pkg::*;
#(
    parameter int TICKS_PER_SEC = 50_000_000
) (
    input  logic         CLK_50M,
    input  logic         rst,
    input  key_event_t   key_evt,
    input  logic         mgmt_waitrequest,
    input  logic         pll_locked,
    input  logic         mem_fail,   // Level from the SDRAM tester
    output mgmt_cmd_t    mgmt,
    output logic         pll_reset,
    output logic         busy,
    output ctrl_status_t status,
    output elapsed_t     elapsed
);

    pll_cfg_t   cfg;
    recfg_req_t req;

    pll_step_table step_table_i (
        .pos (status.pos),
        .cfg (cfg)
    );

    key_cmd_decoder key_cmd_decoder_i (
        .CLK_50M  (CLK_50M),
        .rst      (rst),
        .key_evt  (key_evt),
        .cfg      (cfg),
        .busy     (busy),
        .mem_fail (mem_fail),
        .req      (req),
        .status   (status)
    );

    pll_reconfig_seq pll_reconfig_seq_i (
        .CLK_50M          (CLK_50M),
        .rst              (rst),
        .req              (req),
        .cfg              (cfg),
        .mgmt_waitrequest (mgmt_waitrequest),
        .pll_locked       (pll_locked),
        .mgmt             (mgmt),
        .pll_reset        (pll_reset),
        .busy             (busy)
    );

    elapsed_timer #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) elapsed_timer_i (
        .CLK_50M (CLK_50M),
        .rst     (rst),
        .busy    (busy),
        .elapsed (elapsed)
    );

endmodule

`default_nettype wire

//--- elapsed_timer.sv
`timescale 1ns/1ps
`default_nettype none

module elapsed_timer
    import memtest_pkg::*;
#(
    parameter int TICKS_PER_SEC = 50_000_000
) (
    input  logic     CLK_50M,
    input  logic     rst,
    input  logic     busy,
    output elapsed_t elapsed
);

    localparam int TW = $clog2(TICKS_PER_SEC + 1);

    logic [TW-1:0] tick_cnt;
    logic          sec_tick;
    logic [5:0]    sec_div;   // Seconds within the minute
    logic [15:0]   secs;
    logic [15:0]   mins;
    logic [15:0]   mins_next;

    assign sec_tick = tick_cnt == TW'(TICKS_PER_SEC - 1);

    // BCD increment, each digit carries into the next
    always_comb begin
        logic carry;
        carry     = 1'b1;
        mins_next = mins;
        for (int d = 0; d < 4; d++) begin
            if (carry) begin
                if (mins[d*4 +: 4] == 4'd9) begin
                    mins_next[d*4 +: 4] = 4'd0;
                end else begin
                    mins_next[d*4 +: 4] = mins[d*4 +: 4] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLK_50M) begin
        if (rst || busy) begin
            tick_cnt <= '0;
            sec_div  <= 6'd0;
            secs     <= 16'd0;
            mins     <= 16'd0;
        end else begin
            tick_cnt <= sec_tick ? '0 : tick_cnt + 1'b1;
            if (sec_tick) begin
                secs <= secs + 16'd1;
                if (sec_div == 6'd59) begin
                    sec_div <= 6'd0;
                    mins    <= mins_next;
                end else begin
                    sec_div <= sec_div + 6'd1;
                end
            end
        end
    end

    assign elapsed = '{mins: mins, secs: secs};

endmodule

`default_nettype wire

//--- pll_reconfig_seq.sv
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_seq
    import memtest_pkg::*;
(
    input  logic       CLK_50M,
    input  logic       rst,
    input  recfg_req_t req,
    input  pll_cfg_t   cfg,
    input  logic       mgmt_waitrequest,
    input  logic       pll_locked,
    output mgmt_cmd_t  mgmt,
    output logic       pll_reset,
    output logic       busy
);

    pll_cfg_t    base_cfg;
    logic [31:0] base_phase;
    logic [6:0]  step_cnt;   // Action index in [6:3]
    logic [3:0]  action;
    logic        enable;
    logic        fire;
    logic [31:0] pre_q;
    logic        phase_eq;
    logic        phase_dn;
    logic [31:0] phase_diff;
    mgmt_cmd_t   act_cmd;
    logic        wr_q;
    logic [5:0]  addr_q;
    logic [31:0] data_q;

    // Phase is written relative to step 0
    pll_step_table base_table_i (
        .pos (4'd0),
        .cfg (base_cfg)
    );

    assign base_phase = base_cfg.phase;
    assign action     = step_cnt[6:3];
    assign enable     = (pll_locked && !mgmt_waitrequest) || pll_reset;
    assign fire       = busy && enable && step_cnt[2:0] == 3'd0 && !req.start;

    assign phase_eq   = pre_q == base_phase;
    assign phase_dn   = pre_q < base_phase;
    assign phase_diff = phase_dn ? base_phase - pre_q : pre_q - base_phase;

    always_comb begin
        act_cmd = '0;
        case (action)
            4'd0:  act_cmd.write = 1'b1;  // Start
            4'd1:  act_cmd = '{1'b1, 6'd4, cfg.m};
            4'd2:  act_cmd = '{1'b1, 6'd7, cfg.k};
            4'd3:  act_cmd = '{1'b1, 6'd3, 32'h0001_0000};  // N bypass
            4'd4:  act_cmd = '{1'b1, 6'd5, cfg.c};
            4'd5:  act_cmd = '{1'b1, 6'd5, cfg.c | 32'h0004_0000};
            4'd6:  act_cmd = '{1'b1, 6'd9, 32'd1};  // Charge pump
            4'd7:  act_cmd = '{1'b1, 6'd8, 32'd7};  // Bandwidth
            4'd8:  act_cmd = '{1'b1, 6'd2, 32'd0};  // Apply
            4'd11: act_cmd.write = !phase_eq;
            4'd12: act_cmd = '{1'b1, 6'd6,
                               phase_diff | 32'h0001_0000 | {10'd0, phase_dn, 21'd0}};
            4'd13: act_cmd = '{1'b1, 6'd2, 32'd0};
            default: ;
        endcase
    end

    always_ff @(posedge CLK_50M) begin
        if (rst) begin
            busy      <= 1'b0;
            step_cnt  <= 7'd0;
            wr_q      <= 1'b0;
            pll_reset <= 1'b0;
        end else begin
            wr_q <= fire && act_cmd.write;
            if (req.start) begin
                busy      <= 1'b1;  // Also restarts a running sequence
                step_cnt  <= 7'd0;
                pll_reset <= 1'b0;
            end else if (busy && enable) begin
                step_cnt <= step_cnt + 7'd1;
                if (fire) begin
                    case (action)
                        4'd9:  pll_reset <= 1'b1;
                        4'd10: pll_reset <= 1'b0;
                        4'd11: if (phase_eq) busy <= 1'b0;  // No phase change
                        4'd14: busy <= 1'b0;
                        default: ;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK_50M) begin
        if (fire && act_cmd.write) begin
            addr_q <= act_cmd.address;
            data_q <= act_cmd.writedata;
        end
        if (fire && action == 4'd0)
            pre_q <= req.pre_phase;  // Target for this run
    end

    assign mgmt = '{write: wr_q, address: addr_q, writedata: data_q};

endmodule

`default_nettype wire

//--- key_cmd_decoder.sv
`timescale 1ns/1ps
`include "memtest_config.svh"
`default_nettype none

module key_cmd_decoder
    import memtest_pkg::*;
(
    input  logic         CLK_50M,
    input  logic         rst,
    input  key_event_t   key_evt,
    input  pll_cfg_t     cfg,
    input  logic         busy,
    input  logic         mem_fail,
    output recfg_req_t   req,
    output ctrl_status_t status
);

    localparam logic [3:0] LAST_POS = 4'(`MT_NUM_STEPS - 1);

    logic        toggle_q;
    logic        shift_q;   // Shift key held
    logic        evt_new;
    logic        make_evt;
    logic [3:0]  pos;
    logic        auto_q;
    logic        ph_shift_q;
    logic        start_q;
    logic [31:0] pre_phase;

    assign evt_new  = key_evt.toggle != toggle_q;
    assign make_evt = evt_new && key_evt.pressed;

    always_ff @(posedge CLK_50M) begin
        if (rst) begin
            toggle_q   <= 1'b0;
            shift_q    <= 1'b0;
            pos        <= 4'd0;
            auto_q     <= 1'b0;
            ph_shift_q <= 1'b0;
            start_q    <= 1'b0;
            pre_phase  <= `MT_PH_0;
        end else begin
            toggle_q <= key_evt.toggle;
            start_q  <= 1'b0;

            // cfg follows the new pos one cycle after start
            if (start_q && !ph_shift_q)
                pre_phase <= cfg.phase;

            if (evt_new && key_evt.code == `MT_KEY_SHIFT)
                shift_q <= key_evt.pressed;

            if (make_evt) begin
                case (key_evt.code)
                    `MT_KEY_UP: if (pos > 4'd0) begin
                        pos        <= pos - 4'd1;
                        auto_q     <= 1'b0;
                        ph_shift_q <= 1'b0;
                        start_q    <= 1'b1;
                    end
                    `MT_KEY_DOWN: if (pos < LAST_POS) begin
                        pos        <= pos + 4'd1;
                        auto_q     <= 1'b0;
                        ph_shift_q <= 1'b0;
                        start_q    <= 1'b1;
                    end
                    `MT_KEY_ENTER: begin
                        auto_q     <= 1'b0;
                        ph_shift_q <= shift_q;  // Shift+Enter keeps tuned phase
                        start_q    <= 1'b1;
                    end
                    `MT_KEY_AUTO: begin
                        pos        <= 4'd0;
                        auto_q     <= 1'b1;
                        ph_shift_q <= 1'b0;
                        start_q    <= 1'b1;
                    end
                    `MT_KEY_RIGHT: if (shift_q && pre_phase < `MT_PHASE_MAX) begin
                        pre_phase  <= pre_phase + 32'd1;
                        auto_q     <= 1'b0;
                        ph_shift_q <= 1'b1;
                        start_q    <= 1'b1;
                    end
                    `MT_KEY_LEFT: if (shift_q && pre_phase > 32'd0) begin
                        pre_phase  <= pre_phase - 32'd1;
                        auto_q     <= 1'b0;
                        ph_shift_q <= 1'b1;
                        start_q    <= 1'b1;
                    end
                    default: ;
                endcase
            end else if (auto_q && mem_fail && !busy && !start_q && pos < LAST_POS) begin
                // Failure seen at this step, back off one step
                pos        <= pos + 4'd1;
                ph_shift_q <= 1'b0;
                start_q    <= 1'b1;
            end
        end
    end

    assign req    = '{start: start_q, ph_shift: ph_shift_q, pre_phase: pre_phase};
    assign status = '{pos: pos, auto: auto_q, ph_shift: ph_shift_q,
                      freq_code: cfg.freq_code};

endmodule

`default_nettype wire

//--- pll_step_table.sv
`timescale 1ns/1ps
`include "memtest_config.svh"
`default_nettype none

module pll_step_table
    import memtest_pkg::*;
(
    input  logic [3:0] pos,
    output pll_cfg_t   cfg
);

    always_comb begin
        case (pos)
            4'd0: cfg = '{`MT_M_0, `MT_K_0, `MT_C_0, `MT_PH_0, `MT_FREQ_0};
            4'd1: cfg = '{`MT_M_1, `MT_K_1, `MT_C_1, `MT_PH_1, `MT_FREQ_1};
            4'd2: cfg = '{`MT_M_2, `MT_K_2, `MT_C_2, `MT_PH_2, `MT_FREQ_2};
            4'd3: cfg = '{`MT_M_3, `MT_K_3, `MT_C_3, `MT_PH_3, `MT_FREQ_3};
            4'd4: cfg = '{`MT_M_4, `MT_K_4, `MT_C_4, `MT_PH_4, `MT_FREQ_4};
            4'd5: cfg = '{`MT_M_5, `MT_K_5, `MT_C_5, `MT_PH_5, `MT_FREQ_5};
            4'd6: cfg = '{`MT_M_6, `MT_K_6, `MT_C_6, `MT_PH_6, `MT_FREQ_6};
            4'd7: cfg = '{`MT_M_7, `MT_K_7, `MT_C_7, `MT_PH_7, `MT_FREQ_7};
            4'd8: cfg = '{`MT_M_8, `MT_K_8, `MT_C_8, `MT_PH_8, `MT_FREQ_8};
            4'd9: cfg = '{`MT_M_9, `MT_K_9, `MT_C_9, `MT_PH_9, `MT_FREQ_9};
            // Step 10 and anything out of range
            default: cfg = '{`MT_M_10, `MT_K_10, `MT_C_10, `MT_PH_10, `MT_FREQ_10};
        endcase
    end

endmodule

`default_nettype wire

//--- memtest_pkg.sv
`default_nettype none

package memtest_pkg;

    // Scan event from the keyboard front end
    typedef struct packed {
        logic       toggle;   // Flips once per event
        logic       pressed;  // 1 make, 0 break
        logic [7:0] code;
    } key_event_t;

    // Register words for one frequency step
    typedef struct packed {
        logic [31:0] m;
        logic [31:0] k;
        logic [31:0] c;
        logic [31:0] phase;      // Nominal phase
        logic [11:0] freq_code;
    } pll_cfg_t;

    // PLL management bus write
    typedef struct packed {
        logic        write;
        logic [5:0]  address;
        logic [31:0] writedata;
    } mgmt_cmd_t;

    typedef struct packed {
        logic        start;
        logic        ph_shift;
        logic [31:0] pre_phase;  // Target phase
    } recfg_req_t;

    typedef struct packed {
        logic [3:0]  pos;
        logic        auto;
        logic        ph_shift;
        logic [11:0] freq_code;
    } ctrl_status_t;

    typedef struct packed {
        logic [15:0] mins;  // BCD
        logic [15:0] secs;  // Binary
    } elapsed_t;

endpackage

`default_nettype wire

//--- memtest_config.svh
`ifndef MEMTEST_CONFIG_SVH
`define MEMTEST_CONFIG_SVH

`define MT_NUM_STEPS 11
`define MT_PHASE_MAX 100

// PS/2 set 2 make codes
`define MT_KEY_UP    8'h75
`define MT_KEY_DOWN  8'h72
`define MT_KEY_ENTER 8'h5A
`define MT_KEY_AUTO  8'h1C
`define MT_KEY_RIGHT 8'h74
`define MT_KEY_LEFT  8'h6B
`define MT_KEY_SHIFT 8'h12

// Frequency shown per step, MHz in hex digits
`define MT_FREQ_0  12'h167
`define MT_FREQ_1  12'h160
`define MT_FREQ_2  12'h150
`define MT_FREQ_3  12'h140
`define MT_FREQ_4  12'h130
`define MT_FREQ_5  12'h120
`define MT_FREQ_6  12'h110
`define MT_FREQ_7  12'h100
`define MT_FREQ_8  12'h090
`define MT_FREQ_9  12'h080
`define MT_FREQ_10 12'h070

// PLL multiplier words
`define MT_M_0  32'h0000_0707
`define MT_M_1  32'h0000_0707
`define MT_M_2  32'h0000_0606
`define MT_M_3  32'h0000_0606
`define MT_M_4  32'h0000_0505
`define MT_M_5  32'h0000_0505
`define MT_M_6  32'h0000_0404
`define MT_M_7  32'h0000_0404
`define MT_M_8  32'h0000_0909
`define MT_M_9  32'h0000_0808
`define MT_M_10 32'h0000_0707

// Fractional words
`define MT_K_0  32'hD70A_3D71
`define MT_K_1  32'h3333_3333
`define MT_K_2  32'h0000_0001
`define MT_K_3  32'h6666_6666
`define MT_K_4  32'hCCCC_CCCD
`define MT_K_5  32'h0000_0001
`define MT_K_6  32'h6666_6666
`define MT_K_7  32'h0000_0001
`define MT_K_8  32'h0000_0001
`define MT_K_9  32'h0000_0001
`define MT_K_10 32'h0000_0001

// Output counter words, C1 adds bit 18
`define MT_C_0  32'h0000_0101
`define MT_C_1  32'h0000_0101
`define MT_C_2  32'h0000_0101
`define MT_C_3  32'h0000_0101
`define MT_C_4  32'h0000_0101
`define MT_C_5  32'h0000_0101
`define MT_C_6  32'h0000_0101
`define MT_C_7  32'h0000_0101
`define MT_C_8  32'h0000_0303
`define MT_C_9  32'h0000_0303
`define MT_C_10 32'h0000_0303

// Nominal phase in PLL phase steps
`define MT_PH_0  32'd40
`define MT_PH_1  32'd38
`define MT_PH_2  32'd36
`define MT_PH_3  32'd34
`define MT_PH_4  32'd31
`define MT_PH_5  32'd28
`define MT_PH_6  32'd25
`define MT_PH_7  32'd22
`define MT_PH_8  32'd19
`define MT_PH_9  32'd16
`define MT_PH_10 32'd12

`endif
